// ==== src.f ====
source/eth_rx_pkg.sv
source/buf_bus_if.sv
source/rgmii_nibble_demux.sv
source/preamble_detector.sv
source/frame_writer.sv
source/frame_store.sv
source/host_reader.sv
source/eth_rx_top.sv
bench/rgmii_clock_gen.sv
bench/eth_rx_tb.sv

// ==== Makefile ====
# Verilator flow for the ethernet receive front end

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module eth_rx_top

# the log decides pass or fail
sim:
	verilator --binary --timing --timescale 1ns/100ps -f src.f \
		--top-module eth_rx_tb -o eth_rx_sim
	./obj_dir/eth_rx_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/eth_rx_tb.sv ====
//----------------------------------------------------------
// ethernet receive front end testbench
//----------------------------------------------------------
`timescale 1ns/100ps

module eth_rx_tb;
  import eth_rx_pkg::*;

  localparam int num_frames = 10;
  localparam int ifg_cycles = 12;
  localparam int wait_limit = 400;
  // expected result of one frame
  localparam int out_none = 0;
  localparam int out_post = 1;
  localparam int out_drop = 2;

  typedef struct packed {
    logic gb;
    int   pre;
    int   len;
    logic fcs_good;
    int   err_idx;
    logic twin;
    logic release_head;
    int   outcome;
    logic exp_slot;
  } frame_rec_t;

  typedef struct packed {
    logic slot;
    int   len;
    logic ok;
  } desc_t;

  logic clock;
  logic rst_n;
  logic speed_1gb;
  logic [3:0] rx_data;
  logic rx_ctl;
  logic host_req;
  logic [buf_addr_w-1:0] host_addr;
  logic host_ack;
  logic [7:0] host_rdata;
  logic frame_release;
  logic frame_valid;
  logic frame_slot;
  logic [len_w-1:0] frame_len;
  logic frame_ok;
  logic [7:0] frames_dropped;
  logic active;

  frame_rec_t frames [num_frames];
  // bytes after the sfd, data then fcs low byte first
  logic [7:0] tx_bytes [128];
  // what each slot should hold
  logic [7:0] slot_data [2][1024];
  // posted frames, oldest first
  desc_t posted [$];
  int errors = 0;
  int checks = 0;
  int watchdog_cycles = 0;

  rgmii_clock_gen i_clock_gen (.clock, .rst_n);

  eth_rx_top i_eth_rx_top (
    .clock, .rst_n, .speed_1gb, .rx_data, .rx_ctl,
    .host_req, .host_addr, .host_ack, .host_rdata,
    .frame_release, .frame_valid, .frame_slot, .frame_len, .frame_ok,
    .frames_dropped, .active
  );

  //----------------------------------------------------------
  // frame table
  //----------------------------------------------------------
  task automatic load_table;
    // gb, pre, len, fcs_good, err_idx, twin, release, outcome, slot
    frames[0] = '{1'b1, 7, 64, 1'b1, -1, 1'b0, 1'b1, out_post, 1'b0};
    frames[1] = '{1'b1, 7, 46, 1'b0, -1, 1'b0, 1'b1, out_post, 1'b0};
    frames[2] = '{1'b1, 7, 50, 1'b1, 10, 1'b0, 1'b1, out_post, 1'b0};
    // minimum preamble, then its 100 Mb/s twin
    frames[3] = '{1'b1, 5, 60, 1'b1, -1, 1'b0, 1'b1, out_post, 1'b0};
    frames[4] = '{1'b0, 5, 60, 1'b1, -1, 1'b1, 1'b1, out_post, 1'b0};
    // short preamble, never reaches the writer
    frames[5] = '{1'b1, 4, 40, 1'b1, -1, 1'b0, 1'b0, out_none, 1'b0};
    // fill both slots, then overflow
    frames[6] = '{1'b1, 7, 30, 1'b1, -1, 1'b0, 1'b0, out_post, 1'b0};
    frames[7] = '{1'b1, 7, 33, 1'b1, -1, 1'b0, 1'b0, out_post, 1'b1};
    frames[8] = '{1'b1, 7, 20, 1'b1, -1, 1'b0, 1'b1, out_drop, 1'b0};
    frames[9] = '{1'b1, 7, 25, 1'b1, -1, 1'b0, 1'b1, out_post, 1'b0};
  endtask

  // 16 cycles per line byte covers 100 Mb/s and the host reads
  function automatic int table_cycles();
    int bytes;
    bytes = 0;
    for (int f = 0; f < num_frames; f++) begin
      bytes += frames[f].pre + 1 + frames[f].len + 4;
    end
    return bytes * 16 + 2000;
  endfunction

  //----------------------------------------------------------
  // reference fcs
  //----------------------------------------------------------
  // reflected 802.3 crc over the first count bytes
  function automatic logic [31:0] crc_reflected(input int count);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < count; i++) begin
      c = c ^ {24'h0, tx_bytes[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return c;
  endfunction

  function automatic logic [31:0] bit_reverse(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  //----------------------------------------------------------
  // rgmii driver
  //----------------------------------------------------------
  // one clock, first value after the rise and second after the fall
  task automatic drive_cycle(input logic [3:0] first, input logic [3:0] second,
                             input logic err);
    @(posedge clock);
    #1;
    rx_data = first;
    rx_ctl = 1'b1;
    @(negedge clock);
    #1;
    rx_data = second;
    // second ctl half is dv xor er
    rx_ctl = ~err;
  endtask

  task automatic drive_byte(input logic [7:0] b, input logic err, input logic gb);
    if (gb) begin
      drive_cycle(b[3:0], b[7:4], err);
    end else begin
      // one nibble per clock, low half first
      drive_cycle(b[3:0], b[3:0], err);
      drive_cycle(b[7:4], b[7:4], err);
    end
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #1;
      rx_data = 4'h0;
      rx_ctl = 1'b0;
    end
  endtask

  task automatic send_frame(input frame_rec_t rec);
    logic [31:0] fcs;
    drive_idle(2);
    speed_1gb = rec.gb;
    // a twin reuses the bytes of the frame before it
    if (!rec.twin) begin
      for (int i = 0; i < rec.len; i++) begin
        tx_bytes[i] = 8'($urandom());
      end
    end
    fcs = ~crc_reflected(rec.len);
    if (!rec.fcs_good) begin
      fcs = fcs ^ 32'h0000_0100;
    end
    for (int k = 0; k < 4; k++) begin
      tx_bytes[rec.len + k] = fcs[8*k +: 8];
    end
    for (int i = 0; i < rec.pre; i++) begin
      drive_byte(preamble_byte, 1'b0, rec.gb);
    end
    drive_byte(sfd_byte, 1'b0, rec.gb);
    for (int i = 0; i < rec.len + 4; i++) begin
      drive_byte(tx_bytes[i], i == rec.err_idx, rec.gb);
    end
    drive_idle(ifg_cycles);
  endtask

  //----------------------------------------------------------
  // host side
  //----------------------------------------------------------
  task automatic host_read(input logic [buf_addr_w-1:0] addr, output logic [7:0] data);
    int n;
    n = 0;
    host_addr = addr;
    host_req = 1'b1;
    while (!host_ack && n < wait_limit) begin
      @(posedge clock);
      #1;
      n++;
    end
    data = host_rdata;
    host_req = 1'b0;
    while (host_ack && n < wait_limit) begin
      @(posedge clock);
      #1;
      n++;
    end
    if (n >= wait_limit) begin
      errors++;
      $display("ERROR: host read at %h never completed its handshake", addr);
    end
  endtask

  // descriptor and stored bytes of the oldest posted frame
  task automatic check_head(input int f);
    desc_t d;
    logic [7:0] rd;
    d = posted[0];
    check_value($sformatf("frame %0d valid", f), 32'd1, 32'(frame_valid));
    check_value($sformatf("frame %0d slot", f), 32'(d.slot), 32'(frame_slot));
    check_value($sformatf("frame %0d len", f), d.len, 32'(frame_len));
    check_value($sformatf("frame %0d ok", f), 32'(d.ok), 32'(frame_ok));
    for (int i = 0; i < d.len; i++) begin
      host_read({d.slot, 10'(i)}, rd);
      check_value($sformatf("frame %0d byte %0d", f, i), 32'(slot_data[d.slot][i]), 32'(rd));
    end
  endtask

  task automatic release_head_frame;
    frame_release = 1'b1;
    @(posedge clock);
    #1;
    frame_release = 1'b0;
    void'(posted.pop_front());
  endtask

  // the rise of frame_valid or the drop count marks the end of a frame
  task automatic wait_for_outcome(input int f, input int kind, input logic [7:0] drop_before);
    int n;
    n = 0;
    while (n < wait_limit) begin
      if (kind == out_post && frame_valid) break;
      if (kind == out_drop && frames_dropped != drop_before) break;
      @(posedge clock);
      #1;
      n++;
    end
    if (n >= wait_limit) begin
      errors++;
      $display("ERROR: frame %0d never produced its descriptor or drop count", f);
    end
  endtask

  task automatic run_frame(input int f);
    frame_rec_t rec;
    desc_t d;
    logic [7:0] drop_before;
    logic [7:0] drop_expected;
    rec = frames[f];
    drop_before = frames_dropped;
    send_frame(rec);
    if (rec.outcome != out_none) begin
      wait_for_outcome(f, rec.outcome, drop_before);
    end
    drop_expected = drop_before;
    if (rec.outcome == out_drop) begin
      drop_expected = drop_before + 8'd1;
    end
    check_value($sformatf("frame %0d drops", f), 32'(drop_expected), 32'(frames_dropped));
    if (rec.outcome == out_post) begin
      d.slot = rec.exp_slot;
      d.len = rec.len + 4;
      // ok needs the crc residue and no injected rx_error
      d.ok = (bit_reverse(crc_reflected(d.len)) == crc_residue) && (rec.err_idx < 0);
      posted.push_back(d);
      for (int i = 0; i < d.len; i++) begin
        slot_data[rec.exp_slot][i] = tx_bytes[i];
      end
    end
    if (posted.size() > 0) begin
      check_head(f);
    end else begin
      check_value($sformatf("frame %0d no descriptor", f), 32'd0, 32'(frame_valid));
    end
    if (rec.release_head && posted.size() > 0) begin
      release_head_frame();
    end
  endtask

  //----------------------------------------------------------
  // main sequence and watchdog
  //----------------------------------------------------------
  initial begin
    speed_1gb = 1'b1;
    rx_data = 4'h0;
    rx_ctl = 1'b0;
    host_req = 1'b0;
    host_addr = '0;
    frame_release = 1'b0;
    void'($urandom(32'h58eb_f062));
    load_table();
    watchdog_cycles = table_cycles();
    wait (rst_n === 1'b1);
    check_value("reset frame_valid", 32'd0, 32'(frame_valid));
    check_value("reset host_ack", 32'd0, 32'(host_ack));
    check_value("reset active", 32'd0, 32'(active));
    check_value("reset frames_dropped", 32'd0, 32'(frames_dropped));
    for (int f = 0; f < num_frames; f++) begin
      run_frame(f);
    end
    // last frame still waits in its slot
    if (posted.size() > 0) begin
      check_head(num_frames);
    end
    drive_idle(4);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock);
    $display("ERROR: run still busy after %0d cycles, stopped by the watchdog", watchdog_cycles);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== bench/rgmii_clock_gen.sv ====
//----------------------------------------------------------
// bench clock and reset
//----------------------------------------------------------
`timescale 1ns/100ps

module rgmii_clock_gen (
  output logic clock,
  output logic rst_n
);

  // 8 ns period, 125 MHz
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // reset held low for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== source/eth_rx_top.sv ====
//----------------------------------------------------------
// ethernet receive front end
//----------------------------------------------------------
`timescale 1ns/100ps

module eth_rx_top (
  input  logic                             clock,
  input  logic                             rst_n,
  // rgmii receive pins
  input  logic                             speed_1gb,
  input  logic [3:0]                       rx_data,
  input  logic                             rx_ctl,
  // host read port, four phase
  input  logic                             host_req,
  input  logic [eth_rx_pkg::buf_addr_w-1:0] host_addr,
  output logic                             host_ack,
  output logic [7:0]                       host_rdata,
  // frame descriptor
  input  logic                             frame_release,
  output logic                             frame_valid,
  output logic                             frame_slot,
  output logic [eth_rx_pkg::len_w-1:0]     frame_len,
  output logic                             frame_ok,
  output logic [7:0]                       frames_dropped,
  output logic                             active
);

  logic [7:0] byte_data;
  logic byte_valid;
  logic rx_error;
  logic [7:0] payload_data;
  logic payload_valid;
  logic frame_end;

  buf_bus_if wr_bus ();
  buf_bus_if rd_bus ();

  //----------------------------------------------------------
  // receive path
  //----------------------------------------------------------
  rgmii_nibble_demux i_demux (
    .clock, .rst_n, .speed_1gb, .rx_data, .rx_ctl,
    .byte_data, .byte_valid, .rx_error
  );

  // byte_valid doubles as the delayed data valid
  preamble_detector i_detector (
    .clock, .rst_n, .byte_data, .byte_valid, .dv(byte_valid),
    .payload_data, .payload_valid, .active, .frame_end
  );

  frame_writer i_writer (
    .clock, .rst_n, .payload_data, .payload_valid, .frame_end, .rx_error,
    .frame_release, .bus(wr_bus.requester), .frame_valid, .frame_slot,
    .frame_len, .frame_ok, .frames_dropped
  );

  //----------------------------------------------------------
  // buffer and host side
  //----------------------------------------------------------
  frame_store i_store (.clock, .wr(wr_bus.store), .rd(rd_bus.store));

  host_reader i_reader (
    .clock, .rst_n, .host_req, .host_addr, .host_ack, .host_rdata,
    .bus(rd_bus.requester)
  );

endmodule

// ==== source/host_reader.sv ====
//----------------------------------------------------------
// host read port
//----------------------------------------------------------
`timescale 1ns/100ps

module host_reader (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             host_req,
  input  logic [eth_rx_pkg::buf_addr_w-1:0] host_addr,
  output logic                             host_ack,
  output logic [7:0]                       host_rdata,
  buf_bus_if.requester                     bus
);

  // release_ack waits for the host to drop its request
  typedef enum logic [1:0] {idle, fetch, hold, release_ack} reader_state_t;

  reader_state_t state;

  // one read per request, address held by the host
  assign bus.req = (state == fetch);
  assign bus.we = 1'b0;
  assign bus.addr = host_addr;
  assign bus.wdata = 8'h00;

  always_ff @(posedge clock) begin
    if (state == hold) begin
      host_rdata <= bus.rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state    <= idle;
      host_ack <= 1'b0;
    end else begin
      case (state)
        idle: if (host_req) state <= fetch;
        // may stall while the writer owns the ram
        fetch: if (bus.grant) state <= hold;
        hold: begin
          host_ack <= 1'b1;
          state    <= release_ack;
        end
        release_ack: begin
          if (!host_req) begin
            host_ack <= 1'b0;
            state    <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== source/frame_store.sv ====
//----------------------------------------------------------
// frame buffer and arbiter
//----------------------------------------------------------
`timescale 1ns/100ps

module frame_store (
  input logic      clock,
  buf_bus_if.store wr,
  buf_bus_if.store rd
);
  import eth_rx_pkg::*;

  // two slots of slot_bytes each
  logic [7:0] mem [2**buf_addr_w];
  logic [buf_addr_w-1:0] ram_addr;
  logic [7:0] ram_wdata;
  logic ram_we;
  logic ram_en;
  logic [7:0] rdata_q;

  //----------------------------------------------------------
  // fixed priority arbiter
  //----------------------------------------------------------
  // receive path never waits
  assign wr.grant = wr.req;
  // reader only gets idle writer cycles
  assign rd.grant = rd.req & ~wr.req;

  always_comb begin
    if (wr.req) begin
      ram_addr  = wr.addr;
      ram_wdata = wr.wdata;
      ram_we    = wr.we;
    end else begin
      ram_addr  = rd.addr;
      ram_wdata = rd.wdata;
      ram_we    = rd.req & rd.we;
    end
  end

  assign ram_en = wr.grant | rd.grant;

  //----------------------------------------------------------
  // single port ram
  //----------------------------------------------------------
  // read data lands one clock after the grant
  always_ff @(posedge clock) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end
      // read before write on a shared address
      rdata_q <= mem[ram_addr];
    end
  end

  // one read register serves both buses
  assign wr.rdata = rdata_q;
  assign rd.rdata = rdata_q;

endmodule

// ==== source/frame_writer.sv ====
//----------------------------------------------------------
// frame writer and fcs check
//----------------------------------------------------------
`timescale 1ns/100ps

module frame_writer (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [7:0]                  payload_data,
  input  logic                        payload_valid,
  input  logic                        frame_end,
  input  logic                        rx_error,
  input  logic                        frame_release,
  buf_bus_if.requester                bus,
  output logic                        frame_valid,
  output logic                        frame_slot,
  output logic [eth_rx_pkg::len_w-1:0] frame_len,
  output logic                        frame_ok,
  output logic [7:0]                  frames_dropped
);
  import eth_rx_pkg::*;

  writer_state_t state;
  // one flag per slot, set when its frame is posted
  logic [1:0] full;
  // slot of the oldest posted frame
  logic head;
  logic cur_slot;
  logic [len_w-1:0] byte_cnt;
  logic [31:0] crc;
  logic err_seen;
  logic [len_w-1:0] slot_len [2];
  logic [1:0] slot_ok;
  logic have_free;
  logic free_slot;
  logic wr_slot;
  logic byte_done;

  // crc-32 over one byte, bits enter lsb first as on the wire
  function automatic logic [31:0] crc_next(input logic [31:0] crc_in, input logic [7:0] data);
    logic [31:0] c;
    logic fb;
    c = crc_in;
    for (int i = 0; i < 8; i++) begin
      fb = c[31] ^ data[i];
      c = {c[30:0], 1'b0} ^ (fb ? crc_poly : 32'h0);
    end
    return c;
  endfunction

  assign have_free = ~&full;
  assign free_slot = full[0];
  // a new frame goes to the free slot, later bytes follow cur_slot
  assign wr_slot = (state == idle) ? free_slot : cur_slot;

  // write request in the same cycle the byte arrives
  assign bus.req = payload_valid &
                   (((state == idle) && have_free) ||
                    ((state == write) && (byte_cnt != slot_bytes)));
  assign bus.we = 1'b1;
  assign bus.addr = {wr_slot, byte_cnt[slot_addr_w-1:0]};
  assign bus.wdata = payload_data;
  assign byte_done = bus.req & bus.grant;

  // descriptor of the oldest frame
  assign frame_valid = |full;
  assign frame_slot = head;
  assign frame_len = slot_len[head];
  assign frame_ok = slot_ok[head];

  //----------------------------------------------------------
  // fcs, error flag and descriptor contents
  //----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (byte_done) begin
      crc <= crc_next((state == idle) ? 32'hFFFF_FFFF : crc, payload_data);
    end
    // rx_error leads the payload byte by one clock
    if (state == idle && !payload_valid) begin
      err_seen <= rx_error;
    end else begin
      err_seen <= err_seen | rx_error;
    end
    if (state == post) begin
      slot_len[cur_slot] <= byte_cnt;
      slot_ok[cur_slot]  <= (crc == crc_residue) & ~err_seen;
    end
  end

  //----------------------------------------------------------
  // slot bookkeeping
  //----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state          <= idle;
      full           <= 2'b00;
      head           <= 1'b0;
      cur_slot       <= 1'b0;
      byte_cnt       <= '0;
      frames_dropped <= '0;
    end else begin
      if (byte_done) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
      // the host frees the head, the other slot becomes oldest
      if (frame_release && frame_valid) begin
        full[head] <= 1'b0;
        head       <= ~head;
      end
      case (state)
        idle: begin
          if (payload_valid) begin
            cur_slot <= free_slot;
            state    <= have_free ? write : drop;
          end
        end
        write: begin
          if (frame_end) begin
            state <= post;
          end else if (payload_valid && byte_cnt == slot_bytes) begin
            // longer than a slot
            state <= drop;
          end
        end
        post: begin
          full[cur_slot] <= 1'b1;
          if (!full[~cur_slot]) begin
            head <= cur_slot;
          end
          byte_cnt <= '0;
          state    <= idle;
        end
        drop: begin
          if (frame_end) begin
            frames_dropped <= frames_dropped + 8'd1;
            byte_cnt       <= '0;
            state          <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== source/preamble_detector.sv ====
//----------------------------------------------------------
// preamble and sfd detector
//----------------------------------------------------------
`timescale 1ns/100ps

module preamble_detector (
  input  logic       clock,
  input  logic       rst_n,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  input  logic       dv,
  output logic [7:0] payload_data,
  output logic       payload_valid,
  output logic       active,
  output logic       frame_end
);
  import eth_rx_pkg::*;

  detect_state_t state;
  logic [pre_cnt_w-1:0] pre_cnt;
  logic dv_low_q;
  logic dv_gone;

  // at 100 Mb/s dv drops every second cycle, so two low cycles end a frame
  assign dv_gone = ~dv & dv_low_q;
  assign active = (state == payload);

  always_ff @(posedge clock) begin
    if (byte_valid) begin
      payload_data <= byte_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state         <= wait_dv;
      pre_cnt       <= min_preamble;
      dv_low_q      <= 1'b1;
      payload_valid <= 1'b0;
      frame_end     <= 1'b0;
    end else begin
      dv_low_q      <= ~dv;
      payload_valid <= 1'b0;
      frame_end     <= 1'b0;
      case (state)
        wait_dv, preamble: begin
          if (dv_gone) begin
            state   <= wait_dv;
            pre_cnt <= min_preamble;
          end else if (byte_valid) begin
            state <= preamble;
            if (byte_data == preamble_byte) begin
              // count saturates, long preambles are fine
              if (pre_cnt != '0) begin
                pre_cnt <= pre_cnt - 1'b1;
              end
            end else if (byte_data == sfd_byte && pre_cnt == '0) begin
              state <= payload;
            end else begin
              pre_cnt <= min_preamble;
            end
          end
        end
        payload: begin
          payload_valid <= byte_valid;
          if (dv_gone) begin
            state     <= wait_dv;
            pre_cnt   <= min_preamble;
            frame_end <= 1'b1;
          end
        end
        default: state <= wait_dv;
      endcase
    end
  end

endmodule

// ==== source/rgmii_nibble_demux.sv ====
//----------------------------------------------------------
// rgmii nibble demultiplexer
//----------------------------------------------------------
`timescale 1ns/100ps

module rgmii_nibble_demux (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       speed_1gb,
  input  logic [3:0] rx_data,
  input  logic       rx_ctl,
  output logic [7:0] byte_data,
  output logic       byte_valid,
  output logic       rx_error
);

  // falling edge capture, low nibble and rx_dv
  logic [3:0] fall_nib;
  logic       fall_ctl;
  // pairing stage at the rising edge
  logic [3:0] pair_lo;
  logic [3:0] pair_hi;
  logic       pair_dv;
  logic       pair_err;
  // 100 Mb/s assembly, first nibble of the byte
  logic [3:0] nib_lo;
  logic       err_lo;
  logic       phase;

  // rx_ctl carries rx_dv here, launched after the rising edge
  always_ff @(negedge clock) begin
    fall_nib <= rx_data;
    fall_ctl <= rx_ctl;
  end

  //----------------------------------------------------------
  // data path
  //----------------------------------------------------------
  always_ff @(posedge clock) begin
    pair_lo  <= fall_nib;
    pair_hi  <= rx_data;
    // second ctl value is dv xor er, so a mismatch flags an error
    pair_err <= fall_ctl ^ rx_ctl;
    if (!phase) begin
      nib_lo <= pair_lo;
      err_lo <= pair_err;
    end
    if (speed_1gb) begin
      byte_data <= {pair_hi, pair_lo};
    end else if (pair_dv && phase) begin
      // low half came one clock earlier
      byte_data <= {pair_lo, nib_lo};
    end
  end

  //----------------------------------------------------------
  // valid and error flags
  //----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pair_dv    <= 1'b0;
      phase      <= 1'b0;
      byte_valid <= 1'b0;
      rx_error   <= 1'b0;
    end else begin
      pair_dv <= fall_ctl;
      if (speed_1gb) begin
        phase      <= 1'b0;
        byte_valid <= pair_dv;
        rx_error   <= pair_dv & pair_err;
      end else if (!pair_dv) begin
        // phase realigns on every rise of rx_dv
        phase      <= 1'b0;
        byte_valid <= 1'b0;
        rx_error   <= 1'b0;
      end else begin
        phase      <= ~phase;
        byte_valid <= phase;
        rx_error   <= phase & (err_lo | pair_err);
      end
    end
  end

endmodule

// ==== source/buf_bus_if.sv ====
//----------------------------------------------------------
// frame buffer bus
//----------------------------------------------------------
`timescale 1ns/100ps

interface buf_bus_if;
  import eth_rx_pkg::*;

  // byte wide data path
  localparam int data_w = 8;

  // held by the requester until grant
  logic req;
  // driven by the store, access happens in this cycle
  logic grant;
  logic we;
  logic [buf_addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  // read data, valid one cycle after grant
  logic [data_w-1:0] rdata;

  modport requester (output req, we, addr, wdata, input grant, rdata);

  modport store (input req, we, addr, wdata, output grant, rdata);

endinterface

// ==== source/eth_rx_pkg.sv ====
//----------------------------------------------------------
// ethernet receive definitions
//----------------------------------------------------------

package eth_rx_pkg;

  //----------------------------------------------------------
  // frame buffer geometry
  //----------------------------------------------------------
  // byte address into the shared frame buffer
  localparam int buf_addr_w = 11;
  // address bits inside one slot
  localparam int slot_addr_w = 10;
  // frame length counter, wide enough to hold a full slot
  localparam int len_w = 11;
  localparam logic [len_w-1:0] slot_bytes = 11'd1024;

  //----------------------------------------------------------
  // preamble and delimiter
  //----------------------------------------------------------
  localparam int pre_cnt_w = 3;
  // 0x55 bytes needed before the sfd
  localparam logic [pre_cnt_w-1:0] min_preamble = 3'd5;
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte = 8'hD5;

  //----------------------------------------------------------
  // fcs check
  //----------------------------------------------------------
  // ieee 802.3 generator, shifted msb first
  localparam logic [31:0] crc_poly = 32'h04C11DB7;
  // remainder left behind by a frame with a good fcs
  localparam logic [31:0] crc_residue = 32'hC704DD7B;

  // frame writer states
  typedef enum logic [1:0] {idle, write, post, drop} writer_state_t;

  // preamble detector states
  typedef enum logic [1:0] {wait_dv, preamble, payload} detect_state_t;

endpackage
